// ==== sources.f ====
+incdir+verilog
verilog/aap_pkg.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/exec_control.sv
verilog/aap_exec_top.sv
testbench/tb_aap_exec.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_aap_exec -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
   exit 0
fi
exit 1

// ==== testbench/tb_aap_exec.sv ====
`include "aap_macros.svh"

module tb_aap_exec;
   timeunit 1ns;
   timeprecision 1ps;

   // Stimulus kinds
   localparam int kind_alu   = 0;
   localparam int kind_flow  = 1;
   localparam int kind_noop  = 2;
   localparam int kind_mixed = 3;

   // Test lengths in instructions
   localparam int n_alu_seq = 30;
   localparam int n_wrap    = 6;
   localparam int n_flow    = 80;
   localparam int n_noop    = 30;
   localparam int n_mixed   = 200;
   localparam int n_total   = n_alu_seq * 4 + ((n_alu_seq + 2) / 3) * `AAP_REG_N
                              + n_wrap + n_flow + n_noop + n_mixed;
   localparam int watchdog_cycles = n_total * 4 + 5;

   logic             clk;
   logic             rst;
   aap_pkg::instr_t  instr;
   logic             instr_valid;
   logic             instr_ready;
   logic             exec_done;
   aap_pkg::pc_t     pc;
   logic             carry;
   logic             wb_we;
   aap_pkg::regnum_t wb_regnum;
   aap_pkg::data_t   wb_data;

   // Reference model state
   aap_pkg::data_t   m_regs [`AAP_REG_N];
   aap_pkg::pc_t     m_pc;
   logic             m_carry;
   logic             exp_we;
   aap_pkg::regnum_t exp_regnum;
   aap_pkg::data_t   exp_data;

   logic [31:0] rng_state = 32'd78693;
   int n_checks = 0;
   int n_errors = 0;
   int n_tests = 0;
   int n_failing = 0;
   int test_start_errors = 0;
   logic [5:0] load_vals [8] = '{6'd0, 6'd1, 6'd3, 6'd15, 6'd16, 6'd17, 6'd40, 6'd63};

   aap_exec_top dut0 (
      .clk         (clk),
      .rst         (rst),
      .instr       (instr),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .exec_done   (exec_done),
      .pc          (pc),
      .carry       (carry),
      .wb_we       (wb_we),
      .wb_regnum   (wb_regnum),
      .wb_data     (wb_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Run limit scales with the instruction count
   initial begin
      #(watchdog_cycles * 10);
      $display("Watchdog expired before all instructions were executed");
      $display("Test failed");
      $finish;
   end

   function logic [31:0] xorshift();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // **************************************************
   // Compare tasks
   // **************************************************

   task automatic check_data(input string name, input aap_pkg::data_t exp,
                             input aap_pkg::data_t got);
      n_checks++;
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, got);
         n_errors++;
      end
   endtask

   task automatic check_pc(input string name, input aap_pkg::pc_t exp,
                           input aap_pkg::pc_t got);
      n_checks++;
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, got);
         n_errors++;
      end
   endtask

   task automatic check_regnum(input string name, input aap_pkg::regnum_t exp,
                               input aap_pkg::regnum_t got);
      n_checks++;
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, got);
         n_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic got);
      n_checks++;
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s expected %b, got %b", $time, name, exp, got);
         n_errors++;
      end
   endtask

   // **************************************************
   // Reference model
   // **************************************************

   // Condition code sits in the low three opcode bits
   function automatic logic cond_met(input logic [2:0] code, input aap_pkg::data_t a,
                                     input aap_pkg::data_t b);
      case (code)
         3'd2:    return a == b;
         3'd3:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) <= $signed(b);
         3'd6:    return a < b;
         3'd7:    return a <= b;
         default: return 1'b1;
      endcase
   endfunction

   task automatic model_exec(input aap_pkg::instr_t w);
      aap_pkg::data_t a;
      aap_pkg::data_t b;
      aap_pkg::data_t d;
      aap_pkg::data_t amt;
      logic [16:0]    wide;
      logic [3:0]     op;
      logic           take;
      a = m_regs[w[5:3]];
      b = m_regs[w[2:0]];
      d = m_regs[w[8:6]];
      op = w[12:9];
      exp_we = 1'b0;
      exp_regnum = w[8:6];
      exp_data = '0;
      if (!w[15] && aap_pkg::instr_class_e'(w[14:13]) == aap_pkg::class_alu) begin
         // Immediate forms shift or add by imm3
         amt = (op >= 4'd10 && op <= 4'd14) ? {13'b0, w[2:0]} : b;
         exp_we = (op != 4'd0);
         case (aap_pkg::alu_op_e'(op))
            aap_pkg::op_add, aap_pkg::op_addi: begin
               wide = {1'b0, a} + {1'b0, amt};
               exp_data = wide[15:0];
               m_carry = wide[16];
            end
            aap_pkg::op_sub, aap_pkg::op_subi: begin
               wide = {1'b0, a} - {1'b0, amt};
               exp_data = wide[15:0];
               m_carry = wide[16];
            end
            aap_pkg::op_and: exp_data = a & b;
            aap_pkg::op_or:  exp_data = a | b;
            aap_pkg::op_xor: exp_data = a ^ b;
            aap_pkg::op_asr, aap_pkg::op_asri: begin
               wide = {m_carry, a} >> amt;
               exp_data = (amt >= 16'd17) ? 16'd0 : wide[15:0];
            end
            aap_pkg::op_lsl, aap_pkg::op_lsli: exp_data = (amt >= 16'd16) ? 16'd0 : a << amt;
            aap_pkg::op_lsr, aap_pkg::op_lsri: exp_data = (amt >= 16'd16) ? 16'd0 : a >> amt;
            aap_pkg::op_mov:  exp_data = a;
            aap_pkg::op_movi: exp_data = {10'b0, w[5:0]};
            default:          exp_data = '0;
         endcase
         m_pc = m_pc + 24'd1;
      end else if (!w[15] && aap_pkg::instr_class_e'(w[14:13]) == aap_pkg::class_flow) begin
         take = cond_met(op[2:0], a, b);
         // Link value is the low half of the old pc plus one
         if (op[2:0] == 3'd1) begin
            exp_we = 1'b1;
            exp_regnum = w[2:0];
            exp_data = m_pc[15:0] + 16'd1;
         end
         if (!op[3]) begin
            case (op[2:0])
               3'd0:    m_pc = m_pc + {{15{w[8]}}, w[8:0]};
               3'd1:    m_pc = m_pc + {{18{w[8]}}, w[8:3]};
               default: m_pc = take ? m_pc + {{21{w[8]}}, w[8:6]} : m_pc + 24'd1;
            endcase
         end else begin
            // Absolute target replaces the low 16 bits only
            m_pc = take ? {m_pc[23:16], d} : {m_pc[23:16], m_pc[15:0] + 16'd1};
         end
      end else begin
         m_pc = m_pc + 24'd1;
      end
      if (exp_we) begin
         m_regs[exp_regnum] = exp_data;
      end
   endtask

   // **************************************************
   // Stimulus
   // **************************************************

   function automatic aap_pkg::instr_t make_instr(input int kind);
      logic [31:0] r;
      int          k;
      r = xorshift();
      k = kind;
      if (kind == kind_mixed) begin
         // Mostly ALU and flow words
         k = (r[20:18] < 3'd4) ? kind_alu : (r[20:18] < 3'd6) ? kind_flow : kind_noop;
      end
      case (k)
         kind_alu:  return {3'b000, r[12:0]};
         kind_flow: return {3'b010, r[12:0]};
         default: begin
            case (r[17:16])
               2'd0:    return {3'b001, r[12:0]};
               2'd1:    return {3'b011, r[12:0]};
               default: return {1'b1, r[14:0]};
            endcase
         end
      endcase
   endfunction

   // Offer one word with random valid gaps and check its done cycle
   task automatic run_instr(input aap_pkg::instr_t w);
      logic        accepted;
      logic [31:0] r;
      accepted = 1'b0;
      while (!accepted) begin
         @(posedge clk);
         r = xorshift();
         instr <= w;
         instr_valid <= (r[1:0] != 2'b00);
         @(negedge clk);
         check_bit("exec_done", 1'b0, exec_done);
         check_bit("instr_ready", 1'b1, instr_ready);
         if (instr_valid && instr_ready) begin
            model_exec(w);
            accepted = 1'b1;
         end
      end
      // Valid may stay high in the done cycle without being accepted
      @(posedge clk);
      r = xorshift();
      instr_valid <= r[0];
      @(negedge clk);
      check_bit("exec_done", 1'b1, exec_done);
      check_bit("instr_ready", 1'b0, instr_ready);
      check_bit("wb_we", exp_we, wb_we);
      if (exp_we) begin
         check_regnum("wb_regnum", exp_regnum, wb_regnum);
         check_data("wb_data", exp_data, wb_data);
      end
      check_pc("pc", m_pc, pc);
      check_bit("carry", m_carry, carry);
   endtask

   task automatic finish_test(input string name, input int count);
      n_tests++;
      if (n_errors != test_start_errors) begin
         n_failing++;
      end
      $display("%s: %0d instructions, %0d errors", name, count,
               n_errors - test_start_errors);
      test_start_errors = n_errors;
   endtask

   initial begin
      rst = 1'b1;
      instr = '0;
      instr_valid = 1'b0;
      m_pc = '0;
      m_carry = 1'b0;
      for (int i = 0; i < `AAP_REG_N; i++) begin
         m_regs[i] = '0;
      end
      repeat (5) @(posedge clk);
      rst <= 1'b0;

      // State straight out of reset
      @(negedge clk);
      check_pc("pc", 24'd0, pc);
      check_bit("carry", 1'b0, carry);
      check_bit("exec_done", 1'b0, exec_done);
      check_bit("wb_we", 1'b0, wb_we);
      check_bit("instr_ready", 1'b1, instr_ready);
      finish_test("reset", 0);

      // Every third ALU sequence starts from loaded registers
      for (int seq = 0; seq < n_alu_seq; seq++) begin
         if (seq % 3 == 0) begin
            for (int i = 0; i < `AAP_REG_N; i++) begin
               run_instr({7'b0001111, i[2:0], load_vals[(i + seq) % 8]});
            end
         end
         repeat (4) run_instr(make_instr(kind_alu));
      end
      finish_test("alu", n_alu_seq * 4);

      // r1 gets 0xffff and r2 gets 1
      run_instr({7'b0001111, 3'd1, 6'd0});
      run_instr({3'b000, 4'd11, 3'd1, 3'd1, 3'd1});
      run_instr({7'b0001111, 3'd2, 6'd1});
      // Branching below address zero sets the upper pc bits
      run_instr({3'b010, 4'd0, 9'h100});
      // Jump to low half 0xffff, then a failed JEQ wraps in 16 bits
      run_instr({3'b010, 4'd8, 3'd1, 6'd0});
      run_instr({3'b010, 4'd10, 3'd0, 3'd1, 3'd2});
      finish_test("pc_wrap", n_wrap);

      repeat (n_flow) run_instr(make_instr(kind_flow));
      finish_test("flow", n_flow);

      repeat (n_noop) run_instr(make_instr(kind_noop));
      finish_test("noop", n_noop);

      repeat (n_mixed) run_instr(make_instr(kind_mixed));
      finish_test("mixed", n_mixed);

      $display("Tests: %0d, failing: %0d, checks: %0d, errors: %0d",
               n_tests, n_failing, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== verilog/aap_exec_top.sv ====
module aap_exec_top (
   input  logic             clk,
   input  logic             rst,
   input  aap_pkg::instr_t  instr,
   input  logic             instr_valid,
   output logic             instr_ready,
   output logic             exec_done,
   output aap_pkg::pc_t     pc,
   output logic             carry,
   output logic             wb_we,
   output aap_pkg::regnum_t wb_regnum,
   output aap_pkg::data_t   wb_data
);

   // **************************************************
   // Decode fields
   // **************************************************

   logic                  is_16bit;
   aap_pkg::instr_class_e op_class;
   aap_pkg::alu_op_e      alu_op;
   aap_pkg::flow_op_e     flow_op;
   aap_pkg::regnum_t      rd;
   aap_pkg::regnum_t      ra;
   aap_pkg::regnum_t      rb;
   logic [2:0]            imm3;
   logic [5:0]            imm6;
   aap_pkg::pc_t          simm3;
   aap_pkg::pc_t          simm6;
   aap_pkg::pc_t          simm9;

   // Register file ports
   aap_pkg::data_t        ra_data;
   aap_pkg::data_t        rb_data;
   aap_pkg::data_t        rd_data;
   logic                  rf_we;
   aap_pkg::regnum_t      rf_wnum;
   aap_pkg::data_t        rf_wdata;

   // Execution results
   aap_pkg::data_t        alu_result;
   logic                  alu_carry;
   logic                  alu_writes_carry;
   aap_pkg::pc_t          next_pc;
   logic                  link_we;
   aap_pkg::data_t        link_data;

   instr_decode u_decode (
      .instr    (instr),
      .is_16bit (is_16bit),
      .op_class (op_class),
      .alu_op   (alu_op),
      .flow_op  (flow_op),
      .rd       (rd),
      .ra       (ra),
      .rb       (rb),
      .imm3     (imm3),
      .imm6     (imm6),
      .simm3    (simm3),
      .simm6    (simm6),
      .simm9    (simm9)
   );

   reg_file u_regs (
      .clk     (clk),
      .rst     (rst),
      .ra_num  (ra),
      .rb_num  (rb),
      .rd_num  (rd),
      .ra_data (ra_data),
      .rb_data (rb_data),
      .rd_data (rd_data),
      .we      (rf_we),
      .wnum    (rf_wnum),
      .wdata   (rf_wdata)
   );

   alu u_alu (
      .op           (alu_op),
      .a            (ra_data),
      .b            (rb_data),
      .imm3         (imm3),
      .imm6         (imm6),
      .carry_in     (carry),
      .result       (alu_result),
      .carry_out    (alu_carry),
      .writes_carry (alu_writes_carry)
   );

   // Jump target in rd, link back into rb
   branch_unit u_branch (
      .op        (flow_op),
      .pc        (pc),
      .a         (ra_data),
      .b         (rb_data),
      .d         (rd_data),
      .simm3     (simm3),
      .simm6     (simm6),
      .simm9     (simm9),
      .next_pc   (next_pc),
      .link_we   (link_we),
      .link_data (link_data)
   );

   exec_control u_ctrl (
      .clk              (clk),
      .rst              (rst),
      .instr_valid      (instr_valid),
      .instr_ready      (instr_ready),
      .is_16bit         (is_16bit),
      .op_class         (op_class),
      .rb               (rb),
      .rd               (rd),
      .alu_result       (alu_result),
      .alu_carry        (alu_carry),
      .alu_writes_carry (alu_writes_carry),
      .alu_op           (alu_op),
      .next_pc          (next_pc),
      .link_we          (link_we),
      .link_data        (link_data),
      .rf_we            (rf_we),
      .rf_wnum          (rf_wnum),
      .rf_wdata         (rf_wdata),
      .pc               (pc),
      .carry            (carry),
      .exec_done        (exec_done),
      .wb_we            (wb_we),
      .wb_regnum        (wb_regnum),
      .wb_data          (wb_data)
   );

endmodule

// ==== verilog/exec_control.sv ====
module exec_control (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  instr_valid,
   output logic                  instr_ready,
   input  logic                  is_16bit,
   input  aap_pkg::instr_class_e op_class,
   input  aap_pkg::regnum_t      rb,
   input  aap_pkg::regnum_t      rd,
   input  aap_pkg::data_t        alu_result,
   input  logic                  alu_carry,
   input  logic                  alu_writes_carry,
   input  aap_pkg::alu_op_e      alu_op,
   input  aap_pkg::pc_t          next_pc,
   input  logic                  link_we,
   input  aap_pkg::data_t        link_data,
   output logic                  rf_we,
   output aap_pkg::regnum_t      rf_wnum,
   output aap_pkg::data_t        rf_wdata,
   output aap_pkg::pc_t          pc,
   output logic                  carry,
   output logic                  exec_done,
   output logic                  wb_we,
   output aap_pkg::regnum_t      wb_regnum,
   output aap_pkg::data_t        wb_data
);

   logic           accept;
   logic           commit_we;
   aap_pkg::pc_t   commit_pc;
   logic           commit_carry;

   // Ready again once the done cycle is over
   assign instr_ready = ~exec_done;
   assign accept      = instr_valid & instr_ready;

   // **************************************************
   // Commit select
   // **************************************************

   always_comb begin
      commit_we    = 1'b0;
      rf_wnum      = rd;
      rf_wdata     = alu_result;
      commit_pc    = pc + aap_pkg::pc_t'(1);
      commit_carry = carry;
      if (is_16bit && op_class == aap_pkg::class_alu) begin
         commit_we = (alu_op != aap_pkg::op_nop);
         if (alu_writes_carry) begin
            commit_carry = alu_carry;
         end
      end else if (is_16bit && op_class == aap_pkg::class_flow) begin
         // Link goes to rb
         commit_we = link_we;
         rf_wnum   = rb;
         rf_wdata  = link_data;
         commit_pc = next_pc;
      end
      // Load/store, misc and long words fall through as no-ops
   end

   // Register file writes on the accepting edge
   assign rf_we = accept & commit_we;

   // Architectural state and done flag
   always_ff @(posedge clk) begin
      if (rst) begin
         pc        <= '0;
         carry     <= 1'b0;
         exec_done <= 1'b0;
         wb_we     <= 1'b0;
      end else begin
         exec_done <= accept;
         wb_we     <= rf_we;
         if (accept) begin
            pc    <= commit_pc;
            carry <= commit_carry;
         end
      end
   end

   // Writeback report held alongside exec_done
   always_ff @(posedge clk) begin
      if (accept) begin
         wb_regnum <= rf_wnum;
         wb_data   <= rf_wdata;
      end
   end

   // A done cycle accepts nothing and commits no new state
   a_done_commits_nothing: assert property (
      @(posedge clk) disable iff (rst)
      exec_done |=> !exec_done && $stable(pc) && $stable(carry)
   ) else $error("instruction accepted during the done cycle");

endmodule

// ==== verilog/branch_unit.sv ====
`include "aap_macros.svh"

module branch_unit (
   input  aap_pkg::flow_op_e op,
   input  aap_pkg::pc_t      pc,
   input  aap_pkg::data_t    a,
   input  aap_pkg::data_t    b,
   input  aap_pkg::data_t    d,
   input  aap_pkg::pc_t      simm3,
   input  aap_pkg::pc_t      simm6,
   input  aap_pkg::pc_t      simm9,
   output aap_pkg::pc_t      next_pc,
   output logic              link_we,
   output aap_pkg::data_t    link_data
);

   logic           taken;
   aap_pkg::data_t pc_lo_inc;
   aap_pkg::pc_t   pc_inc;
   aap_pkg::pc_t   abs_target;
   aap_pkg::pc_t   abs_fall;

   // Sequential addresses
   assign pc_inc    = pc + aap_pkg::pc_t'(1);
   assign pc_lo_inc = pc[`AAP_DATA_W-1:0] + aap_pkg::data_t'(1);

   // Absolute forms only touch the low 16 bits
   assign abs_target = {pc[`AAP_PC_W-1:`AAP_DATA_W], d};
   assign abs_fall   = {pc[`AAP_PC_W-1:`AAP_DATA_W], pc_lo_inc};

   // **************************************************
   // Condition on ra and rb
   // **************************************************

   always_comb begin
      case (op)
         aap_pkg::op_beq,  aap_pkg::op_jeq:  taken = (a == b);
         aap_pkg::op_bne,  aap_pkg::op_jne:  taken = (a != b);
         aap_pkg::op_blts, aap_pkg::op_jlts: taken = ($signed(a) < $signed(b));
         aap_pkg::op_bles, aap_pkg::op_jles: taken = ($signed(a) <= $signed(b));
         aap_pkg::op_bltu, aap_pkg::op_jltu: taken = (a < b);
         aap_pkg::op_bleu, aap_pkg::op_jleu: taken = (a <= b);
         // Unconditional forms
         default:                            taken = 1'b1;
      endcase
   end

   // Next pc
   always_comb begin
      case (op)
         aap_pkg::op_bra: next_pc = pc + simm9;
         aap_pkg::op_bal: next_pc = pc + simm6;
         aap_pkg::op_jmp, aap_pkg::op_jal: next_pc = abs_target;
         aap_pkg::op_beq, aap_pkg::op_bne, aap_pkg::op_blts, aap_pkg::op_bles,
         aap_pkg::op_bltu, aap_pkg::op_bleu: begin
            next_pc = taken ? pc + simm3 : pc_inc;
         end
         // Conditional absolute, fall through wraps in 16 bits
         default: next_pc = taken ? abs_target : abs_fall;
      endcase
   end

   // Link holds only the low half of the return address
   assign link_we   = (op == aap_pkg::op_bal) || (op == aap_pkg::op_jal);
   assign link_data = pc_lo_inc;

endmodule

// ==== verilog/alu.sv ====
`include "aap_macros.svh"

module alu (
   input  aap_pkg::alu_op_e op,
   input  aap_pkg::data_t   a,
   input  aap_pkg::data_t   b,
   input  logic [2:0]       imm3,
   input  logic [5:0]       imm6,
   input  logic             carry_in,
   output aap_pkg::data_t   result,
   output logic             carry_out,
   output logic             writes_carry
);

   logic                  use_imm;
   logic                  is_sub;
   aap_pkg::data_t        opnd;
   logic [`AAP_DATA_W:0]  sum;
   logic [`AAP_DATA_W:0]  asr_full;

   // Immediate forms take imm3 in place of rb
   assign use_imm = op inside {aap_pkg::op_addi, aap_pkg::op_subi,
                               aap_pkg::op_asri, aap_pkg::op_lsli,
                               aap_pkg::op_lsri};
   assign opnd    = use_imm ? aap_pkg::data_t'(imm3) : b;

   // 17-bit add or subtract, top bit is carry or borrow
   assign is_sub = (op == aap_pkg::op_sub) || (op == aap_pkg::op_subi);
   assign sum    = is_sub ? {1'b0, a} - {1'b0, opnd}
                          : {1'b0, a} + {1'b0, opnd};

   // Carry shifts in from the top
   assign asr_full = {carry_in, a} >> opnd;

   // **************************************************
   // Result select
   // **************************************************

   always_comb begin
      result       = '0;
      carry_out    = carry_in;
      writes_carry = 1'b0;
      case (op)
         aap_pkg::op_add, aap_pkg::op_sub,
         aap_pkg::op_addi, aap_pkg::op_subi: begin
            result       = sum[`AAP_DATA_W-1:0];
            carry_out    = sum[`AAP_DATA_W];
            writes_carry = 1'b1;
         end
         aap_pkg::op_and:  result = a & b;
         aap_pkg::op_or:   result = a | b;
         aap_pkg::op_xor:  result = a ^ b;
         aap_pkg::op_asr, aap_pkg::op_asri: result = asr_full[`AAP_DATA_W-1:0];
         // Large amounts shift everything out
         aap_pkg::op_lsl, aap_pkg::op_lsli: result = a << opnd;
         aap_pkg::op_lsr, aap_pkg::op_lsri: result = a >> opnd;
         aap_pkg::op_mov:  result = a;
         aap_pkg::op_movi: result = aap_pkg::data_t'(imm6);
         // NOP, nothing gets written
         default:          result = '0;
      endcase
   end

endmodule

// ==== verilog/reg_file.sv ====
`include "aap_macros.svh"

module reg_file (
   input  logic             clk,
   input  logic             rst,
   input  aap_pkg::regnum_t ra_num,
   input  aap_pkg::regnum_t rb_num,
   input  aap_pkg::regnum_t rd_num,
   output aap_pkg::data_t   ra_data,
   output aap_pkg::data_t   rb_data,
   output aap_pkg::data_t   rd_data,
   input  logic             we,
   input  aap_pkg::regnum_t wnum,
   input  aap_pkg::data_t   wdata
);

   aap_pkg::data_t regs [`AAP_REG_N];

   // Three read ports, no latency
   assign ra_data = regs[ra_num];
   assign rb_data = regs[rb_num];
   assign rd_data = regs[rd_num];

   // Single write port
   // All registers start from zero
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `AAP_REG_N; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wnum] <= wdata;
      end
   end

   // Writes come one per instruction, and the execute stage
   // needs a done cycle between instructions
   a_no_back_to_back_write: assert property (
      @(posedge clk) disable iff (rst) we |=> !we
   ) else $error("reg_file written in consecutive cycles");

endmodule

// ==== verilog/instr_decode.sv ====
`include "aap_macros.svh"

module instr_decode (
   input  aap_pkg::instr_t       instr,
   output logic                  is_16bit,
   output aap_pkg::instr_class_e op_class,
   output aap_pkg::alu_op_e      alu_op,
   output aap_pkg::flow_op_e     flow_op,
   output aap_pkg::regnum_t      rd,
   output aap_pkg::regnum_t      ra,
   output aap_pkg::regnum_t      rb,
   output logic [2:0]            imm3,
   output logic [5:0]            imm6,
   output aap_pkg::pc_t          simm3,
   output aap_pkg::pc_t          simm6,
   output aap_pkg::pc_t          simm9
);

   // **************************************************
   // Fixed fields
   // **************************************************

   // Bit 15 clear marks a short instruction
   assign is_16bit = ~instr[15];

   assign op_class = aap_pkg::instr_class_e'(instr[14:13]);

   // One opcode field, two views
   // The consumer picks a view by class
   assign alu_op  = aap_pkg::alu_op_e'(instr[12:9]);
   assign flow_op = aap_pkg::flow_op_e'(instr[12:9]);

   // Register numbers
   assign rd = instr[8:6];
   assign ra = instr[5:3];
   assign rb = instr[2:0];

   // **************************************************
   // Immediates
   // **************************************************

   // Unsigned forms, for ALU immediates and MOVI
   assign imm3 = instr[2:0];
   assign imm6 = instr[5:0];

   // Signed branch offsets, widened to the pc
   assign simm3 = {{(`AAP_PC_W-3){instr[8]}}, instr[8:6]};
   assign simm6 = {{(`AAP_PC_W-6){instr[8]}}, instr[8:3]};
   assign simm9 = {{(`AAP_PC_W-9){instr[8]}}, instr[8:0]};

endmodule

// ==== verilog/aap_pkg.sv ====
`include "aap_macros.svh"

package aap_pkg;

   // Basic data path types
   typedef logic [`AAP_DATA_W-1:0]   data_t;
   typedef logic [`AAP_PC_W-1:0]     pc_t;
   typedef logic [`AAP_REGNUM_W-1:0] regnum_t;
   typedef logic [`AAP_INSTR_W-1:0]  instr_t;

   // Instruction class, bits 14:13 of the word
   typedef enum logic [1:0] {
      class_alu,
      class_ldst,
      class_flow,
      class_misc
   } instr_class_e;

   // ALU class opcodes, bits 12:9
   typedef enum logic [3:0] {
      op_nop,
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      op_asr,
      op_lsl,
      op_lsr,
      op_mov,
      op_addi,
      op_subi,
      op_asri,
      op_lsli,
      op_lsri,
      op_movi
   } alu_op_e;

   // Flow of control opcodes, same bits
   // Bit 3 picks absolute over relative, low bits pick the condition
   typedef enum logic [3:0] {
      op_bra,
      op_bal,
      op_beq,
      op_bne,
      op_blts,
      op_bles,
      op_bltu,
      op_bleu,
      op_jmp,
      op_jal,
      op_jeq,
      op_jne,
      op_jlts,
      op_jles,
      op_jltu,
      op_jleu
   } flow_op_e;

endpackage

// ==== verilog/aap_macros.svh ====
`ifndef AAP_MACROS_SVH
`define AAP_MACROS_SVH

// Register and data path width
`define AAP_DATA_W 16

// Program counter width, instruction word addresses
`define AAP_PC_W 24

// Only the 16-bit instruction encoding is handled
`define AAP_INSTR_W 16

// Register numbers are 3 bits in the short encoding
`define AAP_REGNUM_W 3
`define AAP_REG_N 8

`endif
